// File: alu/alu.sv
module alu (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::word_t   op_a,
    input  cpu_pkg::word_t   shifted,
    input  logic             shift_carry,
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             latch_op_b,
    input  logic             reuse_op_b,
    input  cpu_pkg::flags_t  flags_in,
    output cpu_pkg::word_t   alu_result,
    output cpu_pkg::flags_t  alu_flags
);
    import cpu_pkg::*;

    word_t       op_b_latch;
    word_t       op_b;
    word_t       add_x;
    word_t       add_y;
    logic        add_cin;
    logic [32:0] sum;
    logic        overflow;

    // ****************************************
    // operand B
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            op_b_latch <= '0;
        end else if (latch_op_b) begin
            op_b_latch <= shifted;
        end
    end

    assign op_b = reuse_op_b ? op_b_latch : shifted;

    // ****************************************
    // adder
    // ****************************************

    // subtraction runs as x + ~y + cin, so the carry out is already NOT borrow
    always_comb begin
        add_x   = op_a;
        add_y   = op_b;
        add_cin = 1'b0;

        unique case (alu_op)
            ALU_OP_ADC: begin
                add_cin = flags_in.c;
            end
            ALU_OP_SUB, ALU_OP_CMP: begin
                add_y   = ~op_b;
                add_cin = 1'b1;
            end
            ALU_OP_SBC: begin
                add_y   = ~op_b;
                add_cin = flags_in.c;
            end
            ALU_OP_SUB_REVERSED: begin
                add_x   = op_b;
                add_y   = ~op_a;
                add_cin = 1'b1;
            end
            ALU_OP_SBC_REVERSED: begin
                add_x   = op_b;
                add_y   = ~op_a;
                add_cin = flags_in.c;
            end
            default: begin
                add_x   = op_a;
                add_y   = op_b;
                add_cin = 1'b0;
            end
        endcase
    end

    assign sum      = {1'b0, add_x} + {1'b0, add_y} + {32'b0, add_cin};
    assign overflow = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);

    // ****************************************
    // result and flags
    // ****************************************

    always_comb begin
        unique case (alu_op)
            ALU_OP_MOV:                          alu_result = op_b;
            ALU_OP_NOT:                          alu_result = ~op_b;
            ALU_OP_AND, ALU_OP_TEST:             alu_result = op_a & op_b;
            ALU_OP_XOR, ALU_OP_TEST_EXCLUSIVE:   alu_result = op_a ^ op_b;
            ALU_OP_OR:                           alu_result = op_a | op_b;
            ALU_OP_BIT_CLEAR:                    alu_result = op_a & ~op_b;
            default:                             alu_result = sum[31:0];
        endcase
    end

    always_comb begin
        alu_flags.n = alu_result[31];
        alu_flags.z = (alu_result == '0);

        if (is_logical_op(alu_op)) begin
            alu_flags.c = shift_carry;
            alu_flags.v = flags_in.v;
        end else begin
            alu_flags.c = sum[32];
            alu_flags.v = overflow;
        end
    end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

    // ****************************************
    // data types
    // ****************************************

    typedef logic [31:0] word_t;

    // distance of a single shift, 0 to 31
    typedef logic [4:0] shift_amount_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // ****************************************
    // encodings
    // ****************************************

    typedef enum logic [3:0] {
        ALU_OP_MOV            = 4'h0,
        ALU_OP_NOT            = 4'h1,
        ALU_OP_AND            = 4'h2,
        ALU_OP_TEST           = 4'h3,
        ALU_OP_XOR            = 4'h4,
        ALU_OP_TEST_EXCLUSIVE = 4'h5,
        ALU_OP_OR             = 4'h6,
        ALU_OP_BIT_CLEAR      = 4'h7,
        ALU_OP_ADD            = 4'h8,
        ALU_OP_CMP_NEG        = 4'h9,
        ALU_OP_ADC            = 4'ha,
        ALU_OP_SUB            = 4'hb,
        ALU_OP_CMP            = 4'hc,
        ALU_OP_SBC            = 4'hd,
        ALU_OP_SUB_REVERSED   = 4'he,
        ALU_OP_SBC_REVERSED   = 4'hf
    } alu_op_t;

    typedef enum logic [1:0] {
        SHIFT_LSL = 2'd0,
        SHIFT_LSR = 2'd1,
        SHIFT_ASR = 2'd2,
        SHIFT_ROR = 2'd3
    } shift_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        EXECUTE = 2'd1,
        DONE    = 2'd2
    } seq_state_t;

    // test and compare opcodes write the flags whatever set_flags says
    function automatic logic is_compare_op(input alu_op_t op);
        return op inside {ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE, ALU_OP_CMP, ALU_OP_CMP_NEG};
    endfunction

    // the opcode range 0 to 7 is the logical group
    function automatic logic is_logical_op(input alu_op_t op);
        return ~op[3];
    endfunction

endpackage

// File: exec_unit.f
common/cpu_pkg.sv
shifter/barrel_shifter.sv
alu/alu.sv
hdl/exec_sequencer.sv
hdl/exec_unit.sv
tests/exec_unit_tb.sv

// File: hdl/exec_sequencer.sv
module exec_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cpu_pkg::word_t         op_a_in,
    input  cpu_pkg::word_t         op_b_in,
    input  cpu_pkg::alu_op_t       alu_op_in,
    input  cpu_pkg::shift_t        shift_kind_in,
    input  cpu_pkg::shift_amount_t shift_amount_in,
    input  logic                   set_flags,
    input  logic                   reuse_op_b_in,
    input  cpu_pkg::word_t         alu_result,
    input  cpu_pkg::flags_t        alu_flags,
    output logic                   ack,
    output cpu_pkg::word_t         op_a,
    output cpu_pkg::word_t         op_b_raw,
    output cpu_pkg::alu_op_t       alu_op,
    output cpu_pkg::shift_t        shift_kind,
    output cpu_pkg::shift_amount_t shift_amount,
    output logic                   reuse_op_b,
    output logic                   latch_op_b,
    output cpu_pkg::word_t         result,
    output cpu_pkg::flags_t        flags_q
);
    import cpu_pkg::*;

    seq_state_t state;
    logic       set_flags_q;
    logic       accept;

    assign accept = (state == IDLE) && req;

    // ****************************************
    // handshake FSM
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            ack        <= 1'b0;
            latch_op_b <= 1'b0;
            flags_q    <= '0;
            result     <= '0;
        end else begin
            latch_op_b <= 1'b0;

            unique case (state)
                IDLE: begin
                    if (accept) begin
                        state <= EXECUTE;
                        // a reusing command must not overwrite the value it reads
                        latch_op_b <= ~reuse_op_b_in;
                    end
                end

                EXECUTE: begin
                    result <= alu_result;
                    if (set_flags_q || is_compare_op(alu_op)) begin
                        flags_q <= alu_flags;
                    end
                    ack   <= 1'b1;
                    state <= DONE;
                end

                DONE: begin
                    // hold everything until the requester lets go of req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // command registers, loaded once per accepted command
    always_ff @(posedge clk) begin
        if (accept) begin
            op_a         <= op_a_in;
            op_b_raw     <= op_b_in;
            alu_op       <= alu_op_in;
            shift_kind   <= shift_kind_in;
            shift_amount <= shift_amount_in;
            set_flags_q  <= set_flags;
            reuse_op_b   <= reuse_op_b_in;
        end
    end

endmodule

// File: hdl/exec_unit.sv
module exec_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  cpu_pkg::word_t         op_a,
    input  cpu_pkg::word_t         op_b,
    input  cpu_pkg::alu_op_t       alu_op,
    input  cpu_pkg::shift_t        shift_kind,
    input  cpu_pkg::shift_amount_t shift_amount,
    input  logic                   set_flags,
    input  logic                   reuse_op_b,
    output logic                   ack,
    output cpu_pkg::word_t         result,
    output cpu_pkg::flags_t        flags
);
    import cpu_pkg::*;

    // registered command fields
    word_t         op_a_q;
    word_t         op_b_raw;
    alu_op_t       alu_op_q;
    shift_t        shift_kind_q;
    shift_amount_t shift_amount_q;
    logic          reuse_op_b_q;
    logic          latch_op_b;

    word_t         shifted;
    logic          shift_carry;
    word_t         alu_result;
    flags_t        alu_flags;
    flags_t        flags_q;

    assign flags = flags_q;

    exec_sequencer exec_sequencer_inst (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .op_a_in         (op_a),
        .op_b_in         (op_b),
        .alu_op_in       (alu_op),
        .shift_kind_in   (shift_kind),
        .shift_amount_in (shift_amount),
        .set_flags       (set_flags),
        .reuse_op_b_in   (reuse_op_b),
        .alu_result      (alu_result),
        .alu_flags       (alu_flags),
        .ack             (ack),
        .op_a            (op_a_q),
        .op_b_raw        (op_b_raw),
        .alu_op          (alu_op_q),
        .shift_kind      (shift_kind_q),
        .shift_amount    (shift_amount_q),
        .reuse_op_b      (reuse_op_b_q),
        .latch_op_b      (latch_op_b),
        .result          (result),
        .flags_q         (flags_q)
    );

    barrel_shifter barrel_shifter_inst (
        .value        (op_b_raw),
        .shift_kind   (shift_kind_q),
        .shift_amount (shift_amount_q),
        .carry_in     (flags_q.c),
        .shifted      (shifted),
        .shift_carry  (shift_carry)
    );

    alu alu_inst (
        .clk         (clk),
        .reset       (reset),
        .op_a        (op_a_q),
        .shifted     (shifted),
        .shift_carry (shift_carry),
        .alu_op      (alu_op_q),
        .latch_op_b  (latch_op_b),
        .reuse_op_b  (reuse_op_b_q),
        .flags_in    (flags_q),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags)
    );

endmodule

// File: shifter/barrel_shifter.sv
module barrel_shifter (
    input  cpu_pkg::word_t         value,
    input  cpu_pkg::shift_t        shift_kind,
    input  cpu_pkg::shift_amount_t shift_amount,
    input  logic                   carry_in,
    output cpu_pkg::word_t         shifted,
    output logic                   shift_carry
);
    import cpu_pkg::*;

    // bit index of the last bit shifted out, one for each direction
    logic [5:0] left_index;
    logic [4:0] right_index;

    assign left_index  = 6'd32 - {1'b0, shift_amount};
    assign right_index = shift_amount - 5'd1;

    always_comb begin
        shifted     = value;
        shift_carry = carry_in;

        // an amount of zero leaves both the value and the carry alone
        if (shift_amount != '0) begin
            unique case (shift_kind)
                SHIFT_LSL: begin
                    shifted     = value << shift_amount;
                    shift_carry = value[left_index[4:0]];
                end

                SHIFT_LSR: begin
                    shifted     = value >> shift_amount;
                    shift_carry = value[right_index];
                end

                SHIFT_ASR: begin
                    shifted     = word_t'($signed(value) >>> shift_amount);
                    shift_carry = value[right_index];
                end

                SHIFT_ROR: begin
                    // left_index stays below 32 here, so the two halves never overlap
                    shifted     = (value >> shift_amount) | (value << left_index);
                    shift_carry = value[right_index];
                end

                default: begin
                    shifted     = value;
                    shift_carry = carry_in;
                end
            endcase
        end
    end

endmodule

// File: tests/exec_unit_tb.sv
module exec_unit_tb;
    import cpu_pkg::*;

    localparam int     CLK_PERIOD     = 40;
    localparam int     DRIVE_DELAY    = 2;
    localparam int     MAX_COMMANDS   = 200;
    localparam int     HANDSHAKE_WAIT = 16;
    localparam longint MAX_SIGNED     = 64'sh0000_0000_7fff_ffff;
    localparam longint MIN_SIGNED     = -64'sh0000_0000_8000_0000;

    logic          clk;
    logic          reset;
    logic          req;
    word_t         op_a;
    word_t         op_b;
    alu_op_t       alu_op;
    shift_t        shift_kind;
    shift_amount_t shift_amount;
    logic          set_flags;
    logic          reuse_op_b;
    logic          ack;
    word_t         result;
    flags_t        flags;

    // reference model state, the flag register and the operand B latch
    word_t  model_latch;
    flags_t model_flags;

    int          error_count;
    int          command_count;

    exec_unit exec_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .op_a         (op_a),
        .op_b         (op_b),
        .alu_op       (alu_op),
        .shift_kind   (shift_kind),
        .shift_amount (shift_amount),
        .set_flags    (set_flags),
        .reuse_op_b   (reuse_op_b),
        .ack          (ack),
        .result       (result),
        .flags        (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // each command needs well under ten clocks, back-pressure included
    initial begin
        #(MAX_COMMANDS * 10 * CLK_PERIOD);
        $display("timeout: the run did not finish within the time allowed for the tests");
        $display("Test FAILED");
        $finish;
    end

    // ****************************************
    // compare tasks
    // ****************************************

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s gave %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flags(input flags_t actual, input flags_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s gave nzcv %b, expected %b",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s gave %b, expected %b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************

    task automatic add_with_flags(input word_t x, input word_t y, input logic cin,
                                  output word_t r, output logic c, output logic v);
        longint u;
        longint s;
        u = longint'({32'b0, x}) + longint'({32'b0, y}) + longint'(cin);
        s = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
        r = u[31:0];
        c = u[32];
        v = (s > MAX_SIGNED) || (s < MIN_SIGNED);
    endtask

    // cin is the ARM carry, so the borrow taken in is its inverse
    task automatic subtract_with_flags(input word_t x, input word_t y, input logic cin,
                                       output word_t r, output logic c, output logic v);
        longint u;
        longint s;
        u = longint'({32'b0, x}) - longint'({32'b0, y}) - longint'(!cin);
        s = longint'($signed(x)) - longint'($signed(y)) - longint'(!cin);
        r = u[31:0];
        c = (u >= 0);
        v = (s > MAX_SIGNED) || (s < MIN_SIGNED);
    endtask

    task automatic compute_expected(input alu_op_t op, input word_t a, input word_t b,
                                    input shift_t kind, input shift_amount_t amount,
                                    input logic sf, input logic reuse,
                                    output word_t exp_result, output flags_t exp_flags);
        word_t  sh;
        logic   sh_c;
        word_t  opb;
        word_t  r;
        logic   c;
        logic   v;
        flags_t f;

        sh   = b;
        sh_c = model_flags.c;
        if (amount != 0) begin
            case (kind)
                SHIFT_LSL: begin
                    sh   = b << amount;
                    sh_c = b[32 - amount];
                end
                SHIFT_LSR: begin
                    sh   = b >> amount;
                    sh_c = b[amount - 1];
                end
                SHIFT_ASR: begin
                    sh   = word_t'($signed(b) >>> amount);
                    sh_c = b[amount - 1];
                end
                default: begin
                    sh   = (b >> amount) | (b << (32 - amount));
                    sh_c = b[amount - 1];
                end
            endcase
        end

        opb = reuse ? model_latch : sh;
        if (!reuse) begin
            model_latch = sh;
        end

        // logical opcodes keep these two
        c = sh_c;
        v = model_flags.v;
        case (op)
            ALU_OP_MOV:                        r = opb;
            ALU_OP_NOT:                        r = ~opb;
            ALU_OP_AND, ALU_OP_TEST:           r = a & opb;
            ALU_OP_XOR, ALU_OP_TEST_EXCLUSIVE: r = a ^ opb;
            ALU_OP_OR:                         r = a | opb;
            ALU_OP_BIT_CLEAR:                  r = a & ~opb;
            ALU_OP_ADD, ALU_OP_CMP_NEG:        add_with_flags(a, opb, 1'b0, r, c, v);
            ALU_OP_ADC:                        add_with_flags(a, opb, model_flags.c, r, c, v);
            ALU_OP_SUB, ALU_OP_CMP:            subtract_with_flags(a, opb, 1'b1, r, c, v);
            ALU_OP_SBC:                        subtract_with_flags(a, opb, model_flags.c, r, c, v);
            ALU_OP_SUB_REVERSED:               subtract_with_flags(opb, a, 1'b1, r, c, v);
            default:                           subtract_with_flags(opb, a, model_flags.c, r, c, v);
        endcase

        f.n = r[31];
        f.z = (r == '0);
        f.c = c;
        f.v = v;
        if (sf || op == ALU_OP_TEST || op == ALU_OP_TEST_EXCLUSIVE ||
            op == ALU_OP_CMP || op == ALU_OP_CMP_NEG) begin
            model_flags = f;
        end
        exp_result = r;
        exp_flags  = model_flags;
    endtask

    // ****************************************
    // handshake
    // ****************************************

    task automatic do_command(input alu_op_t op, input word_t a, input word_t b,
                              input shift_t kind, input shift_amount_t amount,
                              input logic sf, input logic reuse, input int hold_cycles,
                              input string what);
        word_t  exp_result;
        flags_t exp_flags;
        int     waited;

        compute_expected(op, a, b, kind, amount, sf, reuse, exp_result, exp_flags);
        command_count++;

        @(posedge clk);
        #DRIVE_DELAY;
        check_bit(ack, 1'b0, "ack before req");
        op_a         = a;
        op_b         = b;
        alu_op       = op;
        shift_kind   = kind;
        shift_amount = amount;
        set_flags    = sf;
        reuse_op_b   = reuse;
        req          = 1'b1;

        waited = 0;
        while (ack !== 1'b1 && waited < HANDSHAKE_WAIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (ack !== 1'b1) begin
            $display("error at %0t: ack never arrived for %s", $time, what);
            error_count++;
        end

        check_word(result, exp_result, what);
        check_flags(flags, exp_flags, what);

        repeat (hold_cycles) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_bit(ack, 1'b1, "ack while req is held");
            check_word(result, exp_result, "result while req is held");
            check_flags(flags, exp_flags, "flags while req is held");
        end

        req    = 1'b0;
        waited = 0;
        while (ack !== 1'b0 && waited < HANDSHAKE_WAIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (ack !== 1'b0) begin
            $display("error at %0t: ack stayed high after req dropped for %s", $time, what);
            error_count++;
        end
    endtask

    function automatic word_t boundary_value(input int index);
        case (index)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // ****************************************
    // directed tests
    // ****************************************

    task automatic test_reset_and_shifts();
        shift_amount_t amounts [3];

        amounts[0] = 5'd0;
        amounts[1] = 5'd1;
        amounts[2] = 5'd31;
        check_bit(ack, 1'b0, "ack after reset");
        check_flags(flags, '0, "flags after reset");
        check_word(result, '0, "result after reset");
        for (int k = 0; k < 4; k++) begin
            // old carry alternates so the zero-amount case sees both values
            do_command(ALU_OP_MOV, '0, {k[0], 31'h1}, SHIFT_LSL, 5'd1, 1'b1, 1'b0, 0,
                       "carry setup");
            for (int i = 0; i < 3; i++) begin
                do_command(ALU_OP_MOV, $urandom, $urandom, shift_t'(k), amounts[i],
                           1'b1, 1'b0, 0, $sformatf("MOV shift %0d by %0d", k, amounts[i]));
            end
        end
    endtask

    task automatic test_logical();
        alu_op_t ops [5];

        ops[0] = ALU_OP_AND;
        ops[1] = ALU_OP_OR;
        ops[2] = ALU_OP_XOR;
        ops[3] = ALU_OP_NOT;
        ops[4] = ALU_OP_BIT_CLEAR;
        // an overflow first, so a kept v is visible
        do_command(ALU_OP_ADD, 32'h7fff_ffff, 32'h1, SHIFT_LSL, 5'd0, 1'b1, 1'b0, 0,
                   "overflow setup");
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 6; j++) begin
                do_command(ops[i], $urandom, $urandom, shift_t'($urandom % 4),
                           shift_amount_t'($urandom % 32), 1'b1, 1'b0, 0,
                           $sformatf("logical opcode %0d", ops[i]));
            end
        end
    endtask

    task automatic test_arithmetic();
        alu_op_t ops [6];

        ops[0] = ALU_OP_ADD;
        ops[1] = ALU_OP_ADC;
        ops[2] = ALU_OP_SUB;
        ops[3] = ALU_OP_SBC;
        ops[4] = ALU_OP_SUB_REVERSED;
        ops[5] = ALU_OP_SBC_REVERSED;
        for (int i = 0; i < 6; i++) begin
            for (int a = 0; a < 5; a++) begin
                for (int step = 0; step < 4; step += 1 + (step == 1)) begin
                    do_command(ops[i], boundary_value(a), boundary_value((a + step) % 5),
                               SHIFT_LSL, 5'd0, 1'b1, 1'b0, 0,
                               $sformatf("arithmetic opcode %0d on bounds", ops[i]));
                end
            end
            for (int j = 0; j < 3; j++) begin
                do_command(ops[i], $urandom, $urandom, SHIFT_LSL, 5'd0, 1'b1, 1'b0, 0,
                           $sformatf("arithmetic opcode %0d on random values", ops[i]));
            end
        end
    endtask

    task automatic test_flag_writes();
        alu_op_t ops [4];

        ops[0] = ALU_OP_TEST;
        ops[1] = ALU_OP_TEST_EXCLUSIVE;
        ops[2] = ALU_OP_CMP;
        ops[3] = ALU_OP_CMP_NEG;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 3; j++) begin
                do_command(ops[i], $urandom, $urandom, shift_t'($urandom % 4),
                           shift_amount_t'($urandom % 32), 1'b0, 1'b0, 0,
                           $sformatf("compare opcode %0d without set_flags", ops[i]));
            end
        end
        // these would all change the flags if they were written
        do_command(ALU_OP_ADD, 32'hffff_ffff, 32'h1, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 0,
                   "ADD without set_flags");
        do_command(ALU_OP_SUB, 32'h0, 32'h1, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 0,
                   "SUB without set_flags");
        do_command(ALU_OP_AND, 32'h0, $urandom, SHIFT_LSR, 5'd1, 1'b0, 1'b0, 0,
                   "AND without set_flags");
        do_command(ALU_OP_MOV, 32'h0, 32'h8000_0000, SHIFT_LSL, 5'd0, 1'b0, 1'b0, 0,
                   "MOV without set_flags");
    endtask

    task automatic test_reuse_op_b();
        do_command(ALU_OP_MOV, '0, $urandom, SHIFT_LSL, 5'd4, 1'b1, 1'b0, 0,
                   "MOV that loads the operand B latch");
        do_command(ALU_OP_ADD, $urandom, $urandom, SHIFT_ROR, 5'd7, 1'b1, 1'b1, 0,
                   "ADD reusing operand B");
        do_command(ALU_OP_XOR, $urandom, $urandom, SHIFT_ASR, 5'd2, 1'b1, 1'b1, 0,
                   "XOR reusing operand B");
        do_command(ALU_OP_SUB, $urandom, $urandom, SHIFT_ASR, 5'd3, 1'b1, 1'b0, 0,
                   "SUB that reloads the latch");
        do_command(ALU_OP_MOV, '0, $urandom, SHIFT_LSR, 5'd9, 1'b1, 1'b1, 0,
                   "MOV reusing operand B");
        do_command(ALU_OP_SUB_REVERSED, $urandom, $urandom, SHIFT_LSL, 5'd0, 1'b1, 1'b1, 0,
                   "reverse subtract reusing operand B");
    endtask

    task automatic test_back_pressure();
        do_command(ALU_OP_ADD, $urandom, $urandom, SHIFT_LSL, 5'd3, 1'b1, 1'b0, 20,
                   "ADD with req held high");
        for (int i = 0; i < 4; i++) begin
            do_command(alu_op_t'($urandom % 16), $urandom, $urandom, shift_t'($urandom % 4),
                       shift_amount_t'($urandom % 32), 1'b1, 1'b0, 0,
                       "back-to-back command");
        end
    endtask

    initial begin
        error_count   = 0;
        command_count = 0;
        // the one seed for the whole run
        void'($urandom(87333));
        reset         = 1'b1;
        req           = 1'b0;
        op_a          = '0;
        op_b          = '0;
        alu_op        = ALU_OP_MOV;
        shift_kind    = SHIFT_LSL;
        shift_amount  = '0;
        set_flags     = 1'b0;
        reuse_op_b    = 1'b0;
        model_latch   = '0;
        model_flags   = '0;

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        test_reset_and_shifts();
        test_logical();
        test_arithmetic();
        test_flag_writes();
        test_reuse_op_b();
        test_back_pressure();

        $display("%0d commands run, %0d errors", command_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
